//--- compile.f
+incdir+include
source/ahb_types_pkg.sv
source/periph_map_pkg.sv
source/ahblite_decoder.sv
source/ahblite_ram.sv
source/ahblite_gpio.sv
source/ahblite_slave_mux.sv
source/ahblite_subsys.sv
tb/tb_clock_gen.sv
tb/tb_ahblite_subsys.sv

//--- include/ahb_sys_params.svh
`ifndef AHB_SYS_PARAMS_SVH
`define AHB_SYS_PARAMS_SVH

// System memory map for the AHB-Lite subsystem
// Decoding is (haddr & REGION) == BASE

// Data RAM window 0x2000_0000 .. 0x2000_FFFF
`define RAM_BASE        32'h2000_0000
`define RAM_REGION      32'hFFFF_0000

// GPIO register window 0x4001_0000 .. 0x4001_00FF
`define GPIO_BASE       32'h4001_0000
`define GPIO_REGION     32'hFFFF_FF00

// Word address bits of the data RAM
// 12 bits give 4K words, i.e. 16 KB, aliased over the 64 KB window
`define RAM_ADDR_BITS   12

// Number of GPIO pins
`define GPIO_WIDTH      16

// Slave enables
// A disabled slave's region is served by the default slave
`define RAM_EN          1'b1
`define GPIO_EN         1'b1

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the AHB-Lite subsystem testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_ahblite_subsys
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f compile.f --top-module "$TOP" -Mdir "$BUILD_DIR" -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    echo "Result: pass"
    exit 0
fi

echo "Result: fail, see $LOG"
exit 1

//--- source/ahb_types_pkg.sv
package ahb_types_pkg;

    // HTRANS encodings
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    // HSIZE encodings, only up to the 32-bit bus width
    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_t;

    // AHB-Lite HRESP is a single bit
    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hresp_t;

endpackage

//--- source/ahblite_decoder.sv
`timescale 1ns/10ps
`include "ahb_sys_params.svh"

module ahblite_decoder (
    input  logic [31:0] haddr,
    output logic        sel_ram,
    output logic        sel_gpio,
    output logic        sel_default
);

    logic ram_hit;
    logic gpio_hit;

    // RAMDATA
    // 0x2000_0000 - 0x2000_FFFF
    assign ram_hit = ((haddr & `RAM_REGION) == `RAM_BASE);

    // GPIO
    // 0x4001_0000 IN DATA
    // 0x4001_0004 OUT ENABLE
    // 0x4001_0008 OUT DATA
    assign gpio_hit = ((haddr & `GPIO_REGION) == `GPIO_BASE);

    // Region hits are gated by the slave enables
    assign sel_ram  = ram_hit && `RAM_EN;
    assign sel_gpio = gpio_hit && `GPIO_EN;

    // Everything else, including disabled regions, goes to the default slave
    // Keeps the select vector one-hot for the multiplexer
    assign sel_default = !(sel_ram || sel_gpio);

endmodule

//--- source/ahblite_gpio.sv
`timescale 1ns/10ps
`include "ahb_sys_params.svh"

module ahblite_gpio (
    input  logic                   hclk,
    input  logic                   rst_n,
    input  logic                   hsel,
    input  logic [31:0]            haddr,
    input  ahb_types_pkg::htrans_t htrans,
    input  logic                   hwrite,
    input  ahb_types_pkg::hsize_t  hsize,
    input  logic [31:0]            hwdata,
    input  logic                   hready,
    output logic [31:0]            rdata,
    output logic                   readyout,
    output ahb_types_pkg::hresp_t  resp,
    input  logic [`GPIO_WIDTH-1:0] gpio_in,
    output logic [`GPIO_WIDTH-1:0] gpio_out,
    output logic [`GPIO_WIDTH-1:0] gpio_oe
);

    import ahb_types_pkg::*;
    import periph_map_pkg::*;

    logic                   accept;
    logic                   active_q;
    logic                   wr_q;
    gpio_reg_t              offset_q;
    logic [`GPIO_WIDTH-1:0] in_meta;
    logic [`GPIO_WIDTH-1:0] in_sync;
    logic [`GPIO_WIDTH-1:0] oe_q;
    logic [`GPIO_WIDTH-1:0] out_q;

    // Every transfer size hits the whole register
    assign accept = hsel && hready && (htrans == NONSEQ || htrans == SEQ);

    // Data phase flags
    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            wr_q     <= 1'b0;
        end else if (hready) begin
            active_q <= accept;
            wr_q     <= accept && hwrite;
        end
    end

    // Word-aligned register offset so sub-word accesses land on the register
    always_ff @(posedge hclk) begin
        if (accept) begin
            offset_q <= gpio_reg_t'({haddr[7:2], 2'b00});
        end
    end

    // Two-flop synchronizer on the pins
    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
        end
    end

    // OUT_EN and OUT_DATA written at the end of the data phase
    // Other offsets drop the write
    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            oe_q  <= '0;
            out_q <= '0;
        end else if (hready && wr_q) begin
            case (offset_q)
                OUT_EN:   oe_q  <= hwdata[`GPIO_WIDTH-1:0];
                OUT_DATA: out_q <= hwdata[`GPIO_WIDTH-1:0];
                default:  ;
            endcase
        end
    end

    // Zero-extended read mux
    // Unknown offsets read zero
    always_comb begin
        rdata = 32'h0;
        if (active_q) begin
            case (offset_q)
                IN_DATA:  rdata = 32'(in_sync);
                OUT_EN:   rdata = 32'(oe_q);
                OUT_DATA: rdata = 32'(out_q);
                default:  rdata = 32'h0;
            endcase
        end
    end

    assign readyout = 1'b1;
    assign resp     = OKAY;
    assign gpio_out = out_q;
    assign gpio_oe  = oe_q;

endmodule

//--- source/ahblite_ram.sv
`timescale 1ns/10ps
`include "ahb_sys_params.svh"

module ahblite_ram (
    input  logic                   hclk,
    input  logic                   rst_n,
    input  logic                   hsel,
    input  logic [31:0]            haddr,
    input  ahb_types_pkg::htrans_t htrans,
    input  logic                   hwrite,
    input  ahb_types_pkg::hsize_t  hsize,
    input  logic [31:0]            hwdata,
    input  logic                   hready,
    output logic [31:0]            rdata,
    output logic                   readyout,
    output ahb_types_pkg::hresp_t  resp
);

    import ahb_types_pkg::*;

    localparam int DEPTH = 1 << `RAM_ADDR_BITS;

    logic [31:0]               mem [0:DEPTH-1];
    logic                      accept;
    logic                      wr_q;
    logic [`RAM_ADDR_BITS-1:0] word_q;
    logic [1:0]                lane_q;
    hsize_t                    size_q;
    logic [3:0]                strb;

    // Valid address phase for this slave
    assign accept = hsel && hready && (htrans == NONSEQ || htrans == SEQ);

    // Pending write in the data phase
    // Held while a stalled data phase elsewhere keeps hready low
    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_q <= 1'b0;
        end else if (hready) begin
            wr_q <= accept && hwrite;
        end
    end

    // Address phase payload
    always_ff @(posedge hclk) begin
        if (accept) begin
            word_q <= haddr[`RAM_ADDR_BITS+1:2];
            lane_q <= haddr[1:0];
            size_q <= hsize;
        end
    end

    // Byte lanes from registered size and low address bits
    always_comb begin
        case (size_q)
            BYTE:    strb = 4'b0001 << lane_q;
            HALF:    strb = lane_q[1] ? 4'b1100 : 4'b0011;
            default: strb = 4'b1111;
        endcase
    end

    // hwdata is valid in the data phase, commit at its closing edge
    always_ff @(posedge hclk) begin
        if (hready && wr_q) begin
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) begin
                    mem[word_q][8*i +: 8] <= hwdata[8*i +: 8];
                end
            end
        end
    end

    // Asynchronous read at the data-phase address
    // Back-to-back write then read returns the merged word
    assign rdata = mem[word_q];

    // Zero wait states, never errors
    assign readyout = 1'b1;
    assign resp     = OKAY;

endmodule

//--- source/ahblite_slave_mux.sv
`timescale 1ns/10ps

module ahblite_slave_mux (
    input  logic                   hclk,
    input  logic                   rst_n,
    input  ahb_types_pkg::htrans_t htrans,
    input  logic                   hready,
    input  logic                   sel_ram,
    input  logic                   sel_gpio,
    input  logic                   sel_default,
    input  logic [31:0]            ram_rdata,
    input  logic                   ram_readyout,
    input  ahb_types_pkg::hresp_t  ram_resp,
    input  logic [31:0]            gpio_rdata,
    input  logic                   gpio_readyout,
    input  ahb_types_pkg::hresp_t  gpio_resp,
    output logic [31:0]            hrdata,
    output logic                   hready_out,
    output ahb_types_pkg::hresp_t  hresp
);

    import ahb_types_pkg::*;
    import periph_map_pkg::*;

    // Default slave progress through its two-cycle error
    typedef enum logic [1:0] {
        DS_IDLE,
        DS_WAIT,
        DS_DONE
    } ds_state_t;

    logic      accept;
    data_sel_t sel_next;
    data_sel_t data_sel;
    ds_state_t ds_state;
    ds_state_t ds_next;

    assign accept = hready && (htrans == NONSEQ || htrans == SEQ);

    // Target for the coming data phase
    always_comb begin
        if (!accept) begin
            sel_next = SEL_NONE;
        end else if (sel_ram) begin
            sel_next = SEL_RAM;
        end else if (sel_gpio) begin
            sel_next = SEL_GPIO;
        end else if (sel_default) begin
            sel_next = SEL_DEFAULT;
        end else begin
            sel_next = SEL_NONE;
        end
    end

    // ERROR with hready low, then ERROR with hready high
    always_comb begin
        ds_next = ds_state;
        case (ds_state)
            DS_WAIT: ds_next = DS_DONE;
            default: ds_next = (accept && sel_default) ? DS_WAIT : DS_IDLE;
        endcase
    end

    // Target only moves on when the current data phase completes
    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            data_sel <= SEL_NONE;
            ds_state <= DS_IDLE;
        end else begin
            ds_state <= ds_next;
            if (hready) begin
                data_sel <= sel_next;
            end
        end
    end

    // Response routing
    always_comb begin
        case (data_sel)
            SEL_RAM: begin
                hrdata     = ram_rdata;
                hready_out = ram_readyout;
                hresp      = ram_resp;
            end
            SEL_GPIO: begin
                hrdata     = gpio_rdata;
                hready_out = gpio_readyout;
                hresp      = gpio_resp;
            end
            SEL_DEFAULT: begin
                hrdata     = 32'h0;
                hready_out = (ds_state == DS_DONE);
                hresp      = ERROR;
            end
            default: begin
                // Idle bus, nothing owes a response
                hrdata     = 32'h0;
                hready_out = 1'b1;
                hresp      = OKAY;
            end
        endcase
    end

endmodule

//--- source/ahblite_subsys.sv
`timescale 1ns/10ps
`include "ahb_sys_params.svh"

module ahblite_subsys (
    input  logic                   hclk,
    input  logic                   rst_n,
    input  logic [31:0]            haddr,
    input  ahb_types_pkg::htrans_t htrans,
    input  logic                   hwrite,
    input  ahb_types_pkg::hsize_t  hsize,
    input  logic [31:0]            hwdata,
    output logic [31:0]            hrdata,
    output logic                   hready,
    output ahb_types_pkg::hresp_t  hresp,
    input  logic [`GPIO_WIDTH-1:0] gpio_in,
    output logic [`GPIO_WIDTH-1:0] gpio_out,
    output logic [`GPIO_WIDTH-1:0] gpio_oe
);

    import ahb_types_pkg::*;

    // Address-phase selects
    logic        sel_ram;
    logic        sel_gpio;
    logic        sel_default;

    // Slave responses
    logic [31:0] ram_rdata;
    logic        ram_readyout;
    hresp_t      ram_resp;
    logic [31:0] gpio_rdata;
    logic        gpio_readyout;
    hresp_t      gpio_resp;

    ahblite_decoder ahblite_decoder_inst (
        .haddr       (haddr),
        .sel_ram     (sel_ram),
        .sel_gpio    (sel_gpio),
        .sel_default (sel_default)
    );

    // hready from the multiplexer is fed back to every slave
    ahblite_ram ahblite_ram_inst (
        .hclk     (hclk),
        .rst_n    (rst_n),
        .hsel     (sel_ram),
        .haddr    (haddr),
        .htrans   (htrans),
        .hwrite   (hwrite),
        .hsize    (hsize),
        .hwdata   (hwdata),
        .hready   (hready),
        .rdata    (ram_rdata),
        .readyout (ram_readyout),
        .resp     (ram_resp)
    );

    ahblite_gpio ahblite_gpio_inst (
        .hclk     (hclk),
        .rst_n    (rst_n),
        .hsel     (sel_gpio),
        .haddr    (haddr),
        .htrans   (htrans),
        .hwrite   (hwrite),
        .hsize    (hsize),
        .hwdata   (hwdata),
        .hready   (hready),
        .rdata    (gpio_rdata),
        .readyout (gpio_readyout),
        .resp     (gpio_resp),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe)
    );

    ahblite_slave_mux ahblite_slave_mux_inst (
        .hclk          (hclk),
        .rst_n         (rst_n),
        .htrans        (htrans),
        .hready        (hready),
        .sel_ram       (sel_ram),
        .sel_gpio      (sel_gpio),
        .sel_default   (sel_default),
        .ram_rdata     (ram_rdata),
        .ram_readyout  (ram_readyout),
        .ram_resp      (ram_resp),
        .gpio_rdata    (gpio_rdata),
        .gpio_readyout (gpio_readyout),
        .gpio_resp     (gpio_resp),
        .hrdata        (hrdata),
        .hready_out    (hready),
        .hresp         (hresp)
    );

endmodule

//--- source/periph_map_pkg.sv
package periph_map_pkg;

    // Target remembered for the data phase
    typedef enum logic [1:0] {
        SEL_NONE    = 2'b00,
        SEL_RAM     = 2'b01,
        SEL_GPIO    = 2'b10,
        SEL_DEFAULT = 2'b11
    } data_sel_t;

    // GPIO register offsets within the 256-byte window
    typedef enum logic [7:0] {
        IN_DATA  = 8'h00,
        OUT_EN   = 8'h04,
        OUT_DATA = 8'h08
    } gpio_reg_t;

endpackage

//--- tb/ahb_patterns.txt
# op addr size wdata pin exp_rdata exp_resp, all hex, one transfer per line
# op 0 idle, 1 busy, 2 write, 3 read; size 0 byte, 1 half, 2 word; resp 0 okay, 1 error
2 20000200 2 11223344 0000 00000000 0
2 20000201 0 0000ab00 0000 00000000 0
2 20000202 1 cdef0000 0000 00000000 0
3 20000200 2 00000000 0000 cdefab44 0
2 20000204 2 a5a5a5a5 0000 00000000 0
2 20000204 1 00001234 0000 00000000 0
2 20000207 0 5a000000 0000 00000000 0
3 20000204 2 00000000 0000 5aa51234 0
2 40010004 2 0000f0f0 0000 00000000 0
2 40010008 2 ffffa5c3 0000 00000000 0
3 40010004 2 00000000 0000 0000f0f0 0
3 40010008 2 00000000 0000 0000a5c3 0
2 4001000c 2 00001234 0000 00000000 0
3 4001000c 2 00000000 0000 00000000 0
0 00000000 2 00000000 beef 00000000 0
0 00000000 2 00000000 beef 00000000 0
3 40010000 2 00000000 beef 0000beef 0
2 40000010 2 deadbeef beef 00000000 1
3 40000010 2 00000000 beef 00000000 1
2 20010200 2 ffffffff beef 00000000 1
2 40010100 2 0000ffff beef 00000000 1
0 20000200 2 0badf00d beef 00000000 0
1 40010008 2 0000ffff beef 00000000 0
3 20000200 2 00000000 beef cdefab44 0
3 40010008 2 00000000 beef 0000a5c3 0

//--- tb/tb_ahblite_subsys.sv
`timescale 1ns/10ps
`include "ahb_sys_params.svh"

module tb_ahblite_subsys;

    import ahb_types_pkg::*;
    import periph_map_pkg::*;

    localparam int          RESET_CYCLES = 10;
    localparam int          FILL_WORDS   = 64;
    localparam logic [31:0] LCG_SEED     = 32'h9076;
    localparam string       PATTERN_FILE = "tb/ahb_patterns.txt";

    // Transfer kinds, same codes as the pattern file
    typedef enum logic [3:0] {
        OP_IDLE  = 4'h0,
        OP_BUSY  = 4'h1,
        OP_WRITE = 4'h2,
        OP_READ  = 4'h3
    } op_t;

    typedef struct packed {
        op_t                    op;
        logic                   wr;
        logic [31:0]            addr;
        logic [2:0]             size;
        logic [31:0]            wdata;
        logic [`GPIO_WIDTH-1:0] pin;
        logic [31:0]            exp_rdata;
        logic                   exp_resp;
        logic                   from_file;
    } xfer_t;

    logic                   hclk;
    logic                   rst_n;
    logic [31:0]            haddr;
    htrans_t                htrans;
    logic                   hwrite;
    hsize_t                 hsize;
    logic [31:0]            hwdata;
    logic [31:0]            hrdata;
    logic                   hready;
    hresp_t                 hresp;
    logic [`GPIO_WIDTH-1:0] gpio_in;
    logic [`GPIO_WIDTH-1:0] gpio_out;
    logic [`GPIO_WIDTH-1:0] gpio_oe;

    // Transfer list, fill first then file lines
    xfer_t xfers[$];
    logic  loaded = 1'b0;

    // Pipeline slots of the master
    xfer_t     ap;
    xfer_t     dp;
    data_sel_t dp_target;
    int        dp_cycle;

    // Reference state
    logic [31:0]            ram_model [0:(1 << `RAM_ADDR_BITS)-1];
    logic [`GPIO_WIDTH-1:0] model_oe  = '0;
    logic [`GPIO_WIDTH-1:0] model_out = '0;

    int checks     = 0;
    int mismatches = 0;
    int failures   = 0;

    tb_clock_gen #(.PERIOD_NS(4)) tb_clock_gen_inst (.hclk(hclk));

    ahblite_subsys ahblite_subsys_inst (
        .hclk     (hclk),
        .rst_n    (rst_n),
        .haddr    (haddr),
        .htrans   (htrans),
        .hwrite   (hwrite),
        .hsize    (hsize),
        .hwdata   (hwdata),
        .hrdata   (hrdata),
        .hready   (hready),
        .hresp    (hresp),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Bus idle slot, pins keep their last value
    function automatic xfer_t idle_filler(input logic [`GPIO_WIDTH-1:0] pin);
        xfer_t x;
        x      = '0;
        x.op   = OP_IDLE;
        x.size = 3'd2;
        x.pin  = pin;
        return x;
    endfunction

    // Expected data-phase target from the memory map
    function automatic data_sel_t target_of(input xfer_t x);
        if (x.op == OP_IDLE || x.op == OP_BUSY) begin
            return SEL_NONE;
        end
        if (`RAM_EN && ((x.addr & `RAM_REGION) == `RAM_BASE)) begin
            return SEL_RAM;
        end
        if (`GPIO_EN && ((x.addr & `GPIO_REGION) == `GPIO_BASE)) begin
            return SEL_GPIO;
        end
        return SEL_DEFAULT;
    endfunction

    // Lane i is written when the access covers it
    function automatic logic [3:0] byte_lanes(input logic [2:0] size, input logic [1:0] low);
        logic [3:0] lanes;
        for (int i = 0; i < 4; i++) begin
            lanes[i] = (size >= 3'd2) ||
                       (size == 3'd1 && i[1] == low[1]) ||
                       (size == 3'd0 && i[1:0] == low);
        end
        return lanes;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            mismatches++;
            $display("Mismatch %s: expected 0x%08h, actual 0x%08h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic print_summary();
        $display("Summary: %0d checks, %0d mismatches, %0d other failures",
                 checks, mismatches, failures);
    endtask

    // 64 LCG words written, then read back in order
    task automatic build_fill();
        logic [31:0] seed;
        xfer_t       x;
        seed = LCG_SEED;
        for (int i = 0; i < FILL_WORDS; i++) begin
            seed    = lcg_next(seed);
            x       = idle_filler('0);
            x.op    = OP_WRITE;
            x.wr    = 1'b1;
            x.addr  = `RAM_BASE + 32'(i * 4);
            x.wdata = seed;
            xfers.push_back(x);
        end
        for (int i = 0; i < FILL_WORDS; i++) begin
            x      = idle_filler('0);
            x.op   = OP_READ;
            x.addr = `RAM_BASE + 32'(i * 4);
            xfers.push_back(x);
        end
    endtask

    task automatic load_patterns();
        int                     fd;
        int                     fields;
        int                     count;
        string                  line;
        logic [3:0]             op_raw;
        logic [31:0]            addr;
        logic [2:0]             size;
        logic [31:0]            wdata;
        logic [`GPIO_WIDTH-1:0] pin;
        logic [31:0]            exp_rdata;
        logic                   exp_resp;
        xfer_t                  x;
        count = 0;
        fd    = $fopen(PATTERN_FILE, "r");
        assert (fd != 0) else begin
            failures++;
            $display("Error: cannot open pattern file %s", PATTERN_FILE);
        end
        if (fd == 0) begin
            return;
        end
        while ($fgets(line, fd) != 0) begin
            // Skip blank and comment lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h %h %h %h",
                             op_raw, addr, size, wdata, pin, exp_rdata, exp_resp);
            assert (fields == 7 && op_raw < 4'h4) else begin
                failures++;
                $display("Error: pattern line cannot be parsed: %s", line);
            end
            if (fields == 7 && op_raw < 4'h4) begin
                x           = '0;
                x.op        = op_t'(op_raw);
                x.wr        = (x.op != OP_READ);
                x.addr      = addr;
                x.size      = size;
                x.wdata     = wdata;
                x.pin       = pin;
                x.exp_rdata = exp_rdata;
                x.exp_resp  = exp_resp;
                x.from_file = 1'b1;
                xfers.push_back(x);
                count++;
            end
        end
        $fclose(fd);
        assert (count > 0) else begin
            failures++;
            $display("Error: pattern file holds no transfers");
        end
    endtask

    function automatic htrans_t trans_of(input op_t op);
        case (op)
            OP_IDLE: return IDLE;
            OP_BUSY: return BUSY;
            default: return NONSEQ;
        endcase
    endfunction

    // Address phase from ap, write data of the running data phase
    task automatic drive_bus();
        haddr   = ap.addr;
        htrans  = trans_of(ap.op);
        hwrite  = ap.wr;
        hsize   = hsize_t'(ap.size);
        hwdata  = dp.wdata;
        gpio_in = ap.pin;
    endtask

    task automatic check_pins();
        check_value("gpio_oe", 32'(model_oe), 32'(gpio_oe));
        check_value("gpio_out", 32'(model_out), 32'(gpio_out));
    endtask

    task automatic check_data_phase();
        logic                      exp_ready;
        logic [`RAM_ADDR_BITS-1:0] word;
        // Default slave stalls for its first cycle only
        exp_ready = !(dp_target == SEL_DEFAULT && dp_cycle == 0);
        word      = dp.addr[`RAM_ADDR_BITS+1:2];
        check_value("hready", 32'(exp_ready), 32'(hready));
        check_value("hresp", 32'(dp.exp_resp), 32'(hresp));
        if (hready && dp.op == OP_READ) begin
            if (dp_target == SEL_RAM) begin
                check_value("hrdata", ram_model[word], hrdata);
            end
            if (dp.from_file || dp_target != SEL_RAM) begin
                check_value("hrdata", dp.exp_rdata, hrdata);
            end
        end
    endtask

    // Data phase closes at the coming edge
    task automatic commit_write(input xfer_t x, input data_sel_t target);
        logic [3:0]                lanes;
        logic [`RAM_ADDR_BITS-1:0] word;
        logic [7:0]                offset;
        lanes  = byte_lanes(x.size, x.addr[1:0]);
        word   = x.addr[`RAM_ADDR_BITS+1:2];
        offset = x.addr[7:0] & 8'hFC;
        if (x.op == OP_WRITE && target == SEL_RAM) begin
            for (int i = 0; i < 4; i++) begin
                if (lanes[i]) begin
                    ram_model[word][8*i +: 8] = x.wdata[8*i +: 8];
                end
            end
        end
        if (x.op == OP_WRITE && target == SEL_GPIO) begin
            if (offset == OUT_EN) begin
                model_oe = x.wdata[`GPIO_WIDTH-1:0];
            end else if (offset == OUT_DATA) begin
                model_out = x.wdata[`GPIO_WIDTH-1:0];
            end
        end
    endtask

    // Pipelined master, one slot shift per completed data phase
    task automatic run_transfers();
        int   idx;
        int   shifts;
        logic moved;
        idx       = 0;
        shifts    = 0;
        moved     = 1'b0;
        dp        = idle_filler('0);
        ap        = dp;
        dp_target = SEL_NONE;
        dp_cycle  = 0;
        while (shifts < xfers.size() + 2) begin
            @(negedge hclk);
            if (moved) begin
                dp        = ap;
                dp_target = target_of(dp);
                dp_cycle  = 0;
                if (idx < xfers.size()) begin
                    ap = xfers[idx];
                    idx++;
                end else begin
                    ap = idle_filler(ap.pin);
                end
                shifts++;
            end
            check_pins();
            check_data_phase();
            drive_bus();
            moved = hready;
            if (hready) begin
                commit_write(dp, dp_target);
            end
            dp_cycle++;
        end
    endtask

    initial begin : master
        rst_n   = 1'b0;
        haddr   = '0;
        htrans  = IDLE;
        hwrite  = 1'b0;
        hsize   = WORD;
        hwdata  = '0;
        gpio_in = '0;
        build_fill();
        load_patterns();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge hclk);
        rst_n = 1'b1;
        run_transfers();
        print_summary();
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Four cycles per transfer is well above the two-cycle worst case
    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = xfers.size() * 4 + RESET_CYCLES;
        repeat (limit) @(posedge hclk);
        failures++;
        $display("Error: watchdog expired after %0d cycles, transfers did not complete", limit);
        print_summary();
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic hclk
);

    // Free-running clock, starts low
    initial begin
        hclk = 1'b0;
    end

    always #(PERIOD_NS / 2) hclk = ~hclk;

endmodule
